// ==== Bender.yml ====
package:
  name: game_top

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/game_pkg.sv
      - hdl/game_master_fsm.sv
      - hdl/sprite_motion.sv
      - hdl/sprite_collision.sv
      - hdl/game_timebase.sv
      - hdl/game_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/game_tb.sv

// ==== game_top.f ====
+incdir+hdl
hdl/game_pkg.sv
hdl/game_master_fsm.sv
hdl/sprite_motion.sv
hdl/sprite_collision.sv
hdl/game_timebase.sv
hdl/game_top.sv
verif/game_tb.sv

// ==== hdl/game_macros.svh ====
`ifndef GAME_MACROS_SVH
`define GAME_MACROS_SVH

// visible playfield in pixels.
`define GAME_SCREEN_W       64
`define GAME_SCREEN_H       48

// both sprites are squares of this edge length.
`define GAME_SPRITE_SIZE    4

// clock cycles between two sprite steps.
`define GAME_FRAME_CYCLES   4

// clock cycles the end state is held before a new round.
`define GAME_END_CYCLES     32

// start position of the target.
`define GAME_TARGET_X0      8
`define GAME_TARGET_Y0      8

// start position of the torpedo, near the bottom edge.
`define GAME_TORPEDO_X0     32
`define GAME_TORPEDO_Y0     44

`endif

// ==== hdl/game_master_fsm.sv ====
`timescale 1ns/10ps

module game_master_fsm
(
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   key,

    input  logic                   target_within_screen,
    input  logic                   torpedo_within_screen,
    input  logic                   collision,
    input  logic                   timer_running,

    output game_pkg::sprite_ctrl_t target_ctrl,
    output game_pkg::sprite_ctrl_t torpedo_ctrl,
    output logic                   timer_start,
    output logic                   won
);

    game_pkg::game_state_e state;
    game_pkg::game_state_e next_state;

    logic end_of_game;

    // a round ends when either sprite is gone or they meet.
    assign end_of_game = ~target_within_screen
                       | ~torpedo_within_screen
                       | collision;

    always_comb
    begin
        next_state = state;

        case (state)
            game_pkg::GAME_START:
            begin
                next_state = game_pkg::GAME_AIM;
            end
            game_pkg::GAME_AIM:
            begin
                if (key)
                    next_state = game_pkg::GAME_SHOOT;
                else if (end_of_game)
                    next_state = game_pkg::GAME_END;
            end
            game_pkg::GAME_SHOOT:
            begin
                if (end_of_game)
                    next_state = game_pkg::GAME_END;
            end
            default:
            begin
                // the timer only runs from the cycle after its start pulse.
                if (!timer_running && !timer_start)
                    next_state = game_pkg::GAME_START;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= game_pkg::GAME_START;
        else
            state <= next_state;
    end

    // outputs follow the next state so they line up with the state register.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            target_ctrl  <= '0;
            torpedo_ctrl <= '0;
            timer_start  <= 1'b0;
            won          <= 1'b0;
        end
        else
        begin
            target_ctrl  <= '0;
            torpedo_ctrl <= '0;

            // the timer starts on the way into the end state only.
            timer_start  <= (next_state == game_pkg::GAME_END)
                         && (state != game_pkg::GAME_END);

            // a hit counts once the torpedo is flying, or while ending.
            if ((state == game_pkg::GAME_SHOOT || state == game_pkg::GAME_END) && collision)
                won <= 1'b1;

            case (next_state)
                game_pkg::GAME_START:
                begin
                    target_ctrl.write_xy  <= 1'b1;
                    target_ctrl.write_dxy <= 1'b1;
                    torpedo_ctrl.write_xy <= 1'b1;
                    won                   <= 1'b0;
                end
                game_pkg::GAME_AIM:
                begin
                    target_ctrl.enable_update <= 1'b1;
                end
                game_pkg::GAME_SHOOT:
                begin
                    torpedo_ctrl.write_dxy     <= 1'b1;
                    target_ctrl.enable_update  <= 1'b1;
                    torpedo_ctrl.enable_update <= 1'b1;
                end
                default:
                begin
                end
            endcase
        end
    end

endmodule

// ==== hdl/game_pkg.sv ====
package game_pkg;

    // round sequencing states.
    typedef enum logic [1:0]
    {
        GAME_START = 2'd0,
        GAME_AIM   = 2'd1,
        GAME_SHOOT = 2'd2,
        GAME_END   = 2'd3
    } game_state_e;

    // unsigned screen position, negative values wrap and land off screen.
    typedef struct packed
    {
        logic [7:0] x;
        logic [7:0] y;
    } sprite_pos_t;

    // signed step per frame tick.
    typedef struct packed
    {
        logic signed [3:0] dx;
        logic signed [3:0] dy;
    } sprite_vel_t;

    typedef struct packed
    {
        logic write_xy;
        logic write_dxy;
        logic enable_update;
    } sprite_ctrl_t;

    typedef struct packed
    {
        logic won;
        logic over;
    } game_status_t;

endpackage

// ==== hdl/game_timebase.sv ====
`timescale 1ns/10ps

`include "game_macros.svh"

module game_timebase
(
    input  logic clk,
    input  logic reset,

    input  logic timer_start,

    output logic frame_tick,
    output logic timer_running
);

    localparam int FRAME_W = $clog2(`GAME_FRAME_CYCLES);
    localparam int END_W   = $clog2(`GAME_END_CYCLES + 1);

    logic [FRAME_W-1:0] frame_cnt;
    logic [END_W-1:0]   end_cnt;

    // free running, wraps after the last cycle of a frame.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            frame_cnt <= '0;
        else if (frame_tick)
            frame_cnt <= '0;
        else
            frame_cnt <= frame_cnt + 1'b1;
    end

    assign frame_tick = (frame_cnt == FRAME_W'(`GAME_FRAME_CYCLES - 1));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            end_cnt <= '0;
        else if (timer_start)
            end_cnt <= END_W'(`GAME_END_CYCLES);
        else if (end_cnt != '0)
            end_cnt <= end_cnt - 1'b1;
    end

    assign timer_running = (end_cnt != '0);

endmodule

// ==== hdl/game_top.sv ====
`timescale 1ns/10ps

`include "game_macros.svh"

module game_top
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  key,
    input  game_pkg::sprite_vel_t target_vel,
    input  game_pkg::sprite_vel_t torpedo_vel,

    output game_pkg::sprite_pos_t target_pos,
    output game_pkg::sprite_pos_t torpedo_pos,
    output game_pkg::game_status_t status
);

    game_pkg::sprite_ctrl_t target_ctrl;
    game_pkg::sprite_ctrl_t torpedo_ctrl;

    logic target_within_screen;
    logic torpedo_within_screen;
    logic collision;
    logic timer_start;
    logic timer_running;
    logic frame_tick;
    logic won;

    game_master_fsm i_fsm
    (
        .clk                   (clk),
        .reset                 (reset),
        .key                   (key),
        .target_within_screen  (target_within_screen),
        .torpedo_within_screen (torpedo_within_screen),
        .collision             (collision),
        .timer_running         (timer_running),
        .target_ctrl           (target_ctrl),
        .torpedo_ctrl          (torpedo_ctrl),
        .timer_start           (timer_start),
        .won                   (won)
    );

    sprite_motion
    #(
        .START_X (8'(`GAME_TARGET_X0)),
        .START_Y (8'(`GAME_TARGET_Y0))
    )
    i_target
    (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (target_ctrl),
        .vel_in        (target_vel),
        .frame_tick    (frame_tick),
        .pos           (target_pos),
        .within_screen (target_within_screen)
    );

    sprite_motion
    #(
        .START_X (8'(`GAME_TORPEDO_X0)),
        .START_Y (8'(`GAME_TORPEDO_Y0))
    )
    i_torpedo
    (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (torpedo_ctrl),
        .vel_in        (torpedo_vel),
        .frame_tick    (frame_tick),
        .pos           (torpedo_pos),
        .within_screen (torpedo_within_screen)
    );

    sprite_collision i_collision
    (
        .target_pos  (target_pos),
        .torpedo_pos (torpedo_pos),
        .collision   (collision)
    );

    game_timebase i_timebase
    (
        .clk           (clk),
        .reset         (reset),
        .timer_start   (timer_start),
        .frame_tick    (frame_tick),
        .timer_running (timer_running)
    );

    assign status.won  = won;
    assign status.over = timer_running;

endmodule

// ==== hdl/sprite_collision.sv ====
`timescale 1ns/10ps

`include "game_macros.svh"

module sprite_collision
(
    input  game_pkg::sprite_pos_t target_pos,
    input  game_pkg::sprite_pos_t torpedo_pos,

    output logic                  collision
);

    // one axis overlaps when each start lies before the other's end.
    function automatic logic axis_overlap(input logic [7:0] a, input logic [7:0] b);
        logic [8:0] a_end;
        logic [8:0] b_end;
        a_end = {1'b0, a} + 9'(`GAME_SPRITE_SIZE);
        b_end = {1'b0, b} + 9'(`GAME_SPRITE_SIZE);
        return ({1'b0, a} < b_end) && ({1'b0, b} < a_end);
    endfunction

    logic x_overlap;
    logic y_overlap;

    assign x_overlap = axis_overlap(target_pos.x, torpedo_pos.x);
    assign y_overlap = axis_overlap(target_pos.y, torpedo_pos.y);

    assign collision = x_overlap && y_overlap;

endmodule

// ==== hdl/sprite_motion.sv ====
`timescale 1ns/10ps

`include "game_macros.svh"

module sprite_motion
#(
    parameter logic [7:0] START_X = 8'd0,
    parameter logic [7:0] START_Y = 8'd0
)
(
    input  logic                   clk,
    input  logic                   reset,

    input  game_pkg::sprite_ctrl_t ctrl,
    input  game_pkg::sprite_vel_t  vel_in,
    input  logic                   frame_tick,

    output game_pkg::sprite_pos_t  pos,
    output logic                   within_screen
);

    game_pkg::sprite_vel_t vel;

    logic [7:0] step_x;
    logic [7:0] step_y;

    // sign extend the velocity so the add wraps modulo 256.
    assign step_x = {{4{vel.dx[3]}}, vel.dx};
    assign step_y = {{4{vel.dy[3]}}, vel.dy};

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pos.x <= START_X;
            pos.y <= START_Y;
        end
        else if (ctrl.write_xy)
        begin
            pos.x <= START_X;
            pos.y <= START_Y;
        end
        else if (ctrl.enable_update && frame_tick)
        begin
            pos.x <= pos.x + step_x;
            pos.y <= pos.y + step_y;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            vel <= '0;
        else if (ctrl.write_dxy)
            vel <= vel_in;
    end

    // a wrapped negative coordinate is large and fails these tests.
    assign within_screen = (pos.x < 8'(`GAME_SCREEN_W))
                        && (pos.y < 8'(`GAME_SCREEN_H));

endmodule

// ==== verif/game_tb.sv ====
`timescale 1ns/10ps

`include "game_macros.svh"

module game_tb;

    localparam int ROUNDS    = 40;
    localparam int ROUND_MAX = 48 + `GAME_SCREEN_W * `GAME_FRAME_CYCLES + `GAME_END_CYCLES + 32;
    localparam int LIMIT_NS  = (16 + ROUNDS * ROUND_MAX) * 10;

    localparam game_pkg::sprite_pos_t TARGET_START  = {8'(`GAME_TARGET_X0), 8'(`GAME_TARGET_Y0)};
    localparam game_pkg::sprite_pos_t TORPEDO_START = {8'(`GAME_TORPEDO_X0), 8'(`GAME_TORPEDO_Y0)};

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   key;
    game_pkg::sprite_vel_t  target_vel;
    game_pkg::sprite_vel_t  torpedo_vel;
    game_pkg::sprite_pos_t  target_pos;
    game_pkg::sprite_pos_t  torpedo_pos;
    game_pkg::game_status_t status;

    int error_count = 0;

    // model registers.
    game_pkg::game_state_e  m_state;
    game_pkg::sprite_ctrl_t m_tctrl;
    game_pkg::sprite_ctrl_t m_pctrl;
    game_pkg::sprite_pos_t  m_tpos;
    game_pkg::sprite_pos_t  m_ppos;
    game_pkg::sprite_vel_t  m_tvel;
    game_pkg::sprite_vel_t  m_pvel;
    logic                   m_timer_start;
    logic                   m_won;
    int                     m_frame_cnt;
    int                     m_end_cnt;

    game_top i_dut
    (
        .clk         (clk),
        .reset       (reset),
        .key         (key),
        .target_vel  (target_vel),
        .torpedo_vel (torpedo_vel),
        .target_pos  (target_pos),
        .torpedo_pos (torpedo_pos),
        .status      (status)
    );

    always #5 clk = ~clk;

    function automatic int comp_to_int(input logic [3:0] c);
        return c[3] ? int'(c) - 16 : int'(c);
    endfunction

    // positions wrap modulo 256.
    function automatic game_pkg::sprite_pos_t step_pos(input game_pkg::sprite_pos_t p,
                                                       input game_pkg::sprite_vel_t v);
        game_pkg::sprite_pos_t n;
        n.x = 8'((int'(p.x) + comp_to_int(v.dx) + 256) % 256);
        n.y = 8'((int'(p.y) + comp_to_int(v.dy) + 256) % 256);
        return n;
    endfunction

    function automatic bit in_screen(input game_pkg::sprite_pos_t p);
        return (int'(p.x) < `GAME_SCREEN_W) && (int'(p.y) < `GAME_SCREEN_H);
    endfunction

    function automatic bit boxes_overlap(input game_pkg::sprite_pos_t a,
                                         input game_pkg::sprite_pos_t b);
        int ddx;
        int ddy;
        ddx = int'(a.x) - int'(b.x);
        ddy = int'(a.y) - int'(b.y);
        if (ddx < 0)
            ddx = -ddx;
        if (ddy < 0)
            ddy = -ddy;
        return (ddx < `GAME_SPRITE_SIZE) && (ddy < `GAME_SPRITE_SIZE);
    endfunction

    // each component in -3..+3, never standing still.
    function automatic game_pkg::sprite_vel_t draw_vel();
        game_pkg::sprite_vel_t v;
        do
        begin
            v.dx = 4'(int'($urandom % 7) - 3);
            v.dy = 4'(int'($urandom % 7) - 3);
        end
        while (v.dx == 4'd0 && v.dy == 4'd0);
        return v;
    endfunction

    task automatic compare_pos(input string what, input game_pkg::sprite_pos_t got,
                               input game_pkg::sprite_pos_t exp);
        if (got !== exp)
        begin
            error_count++;
            $display("FAILED at %0t: %s position (%0d,%0d), expected (%0d,%0d)",
                     $time, what, got.x, got.y, exp.x, exp.y);
        end
    endtask

    task automatic compare_status(input game_pkg::game_status_t got,
                                  input game_pkg::game_status_t exp);
        if (got !== exp)
        begin
            error_count++;
            $display("FAILED at %0t: status won=%0b over=%0b, expected won=%0b over=%0b",
                     $time, got.won, got.over, exp.won, exp.over);
        end
    endtask

    always @(posedge clk or posedge reset)
    begin : cycle_model
        game_pkg::game_state_e nstate;
        bit tick;
        bit col;
        bit eog;
        if (reset)
        begin
            m_state       = game_pkg::GAME_START;
            m_tctrl       = '0;
            m_pctrl       = '0;
            m_tpos        = TARGET_START;
            m_ppos        = TORPEDO_START;
            m_tvel        = '0;
            m_pvel        = '0;
            m_timer_start = 1'b0;
            m_won         = 1'b0;
            m_frame_cnt   = 0;
            m_end_cnt     = 0;
        end
        else
        begin
            tick   = (m_frame_cnt == `GAME_FRAME_CYCLES - 1);
            col    = boxes_overlap(m_tpos, m_ppos);
            eog    = !in_screen(m_tpos) || !in_screen(m_ppos) || col;
            nstate = m_state;
            case (m_state)
                game_pkg::GAME_START:
                    nstate = game_pkg::GAME_AIM;
                game_pkg::GAME_AIM:
                    if (key)
                        nstate = game_pkg::GAME_SHOOT;
                    else if (eog)
                        nstate = game_pkg::GAME_END;
                game_pkg::GAME_SHOOT:
                    if (eog)
                        nstate = game_pkg::GAME_END;
                default:
                    // the hold is over only after the timer has been started and ran out.
                    if (m_end_cnt == 0 && !m_timer_start)
                        nstate = game_pkg::GAME_START;
            endcase

            // sprites and timers act on the strobes registered last cycle.
            if (m_tctrl.write_xy)
                m_tpos = TARGET_START;
            else if (m_tctrl.enable_update && tick)
                m_tpos = step_pos(m_tpos, m_tvel);
            if (m_pctrl.write_xy)
                m_ppos = TORPEDO_START;
            else if (m_pctrl.enable_update && tick)
                m_ppos = step_pos(m_ppos, m_pvel);
            if (m_tctrl.write_dxy)
                m_tvel = target_vel;
            if (m_pctrl.write_dxy)
                m_pvel = torpedo_vel;
            if (m_timer_start)
                m_end_cnt = `GAME_END_CYCLES;
            else if (m_end_cnt != 0)
                m_end_cnt = m_end_cnt - 1;
            m_frame_cnt = tick ? 0 : m_frame_cnt + 1;

            if ((m_state == game_pkg::GAME_SHOOT || m_state == game_pkg::GAME_END) && col)
                m_won = 1'b1;
            m_timer_start = (nstate == game_pkg::GAME_END) && (m_state != game_pkg::GAME_END);
            m_tctrl = '0;
            m_pctrl = '0;
            case (nstate)
                game_pkg::GAME_START:
                begin
                    m_tctrl.write_xy  = 1'b1;
                    m_tctrl.write_dxy = 1'b1;
                    m_pctrl.write_xy  = 1'b1;
                    m_won             = 1'b0;
                end
                game_pkg::GAME_AIM:
                    m_tctrl.enable_update = 1'b1;
                game_pkg::GAME_SHOOT:
                begin
                    m_pctrl.write_dxy     = 1'b1;
                    m_tctrl.enable_update = 1'b1;
                    m_pctrl.enable_update = 1'b1;
                end
                default:
                begin
                end
            endcase
            m_state = nstate;
        end
    end

    always @(negedge clk)
    begin : cycle_check
        game_pkg::game_status_t exp_status;
        exp_status.won  = m_won;
        exp_status.over = (m_end_cnt != 0);
        compare_pos("target", target_pos, m_tpos);
        compare_pos("torpedo", torpedo_pos, m_ppos);
        compare_status(status, exp_status);
    end

    initial
    begin : watchdog
        #(LIMIT_NS);
        $display("watchdog: the rounds did not finish within %0d ns", LIMIT_NS);
        $display("TB FAILED");
        $finish;
    end

    initial
    begin : stimulus
        game_pkg::sprite_vel_t  nxt_t;
        game_pkg::sprite_vel_t  nxt_p;
        game_pkg::game_status_t exp_status;
        int    round_idx;
        int    cycles;
        int    delay;
        int    start_errors;
        int    hits;
        int    misses;
        int    idle;
        int    bad_rounds;
        bit    press;
        bit    shot;
        bit    hit;
        bit    in_end;
        string kind;
        void'($urandom(32'h3a38e08f));
        hits        = 0;
        misses      = 0;
        idle        = 0;
        bad_rounds  = 0;
        reset       = 1'b1;
        key         = 1'b0;
        target_vel  = draw_vel();
        torpedo_vel = draw_vel();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        exp_status = '0;
        compare_pos("target after reset", target_pos, TARGET_START);
        compare_pos("torpedo after reset", torpedo_pos, TORPEDO_START);
        compare_status(status, exp_status);

        for (round_idx = 0; round_idx < ROUNDS; round_idx++)
        begin
            start_errors = error_count;
            // the target has no velocity in the first round, so it needs a shot.
            press  = (round_idx == 0) || ($urandom % 3 != 0);
            delay  = $urandom % 48;
            nxt_t  = draw_vel();
            nxt_p  = draw_vel();
            shot   = 1'b0;
            hit    = 1'b0;
            in_end = 1'b0;
            cycles = 0;
            do
                @(negedge clk);
            while (m_state != game_pkg::GAME_AIM);
            // a new round starts only after the end hold has run out.
            exp_status.won  = 1'b0;
            exp_status.over = 1'b0;
            compare_pos("target at round start", target_pos, TARGET_START);
            compare_pos("torpedo at round start", torpedo_pos, TORPEDO_START);
            compare_status(status, exp_status);

            while (m_state != game_pkg::GAME_START)
            begin
                @(posedge clk);
                key <= press && (cycles == delay);
                // next round's target velocity must be steady through its start state.
                if (in_end)
                begin
                    target_vel  <= nxt_t;
                    torpedo_vel <= nxt_p;
                end
                @(negedge clk);
                cycles++;
                in_end = (m_state == game_pkg::GAME_END);
                if (m_state == game_pkg::GAME_SHOOT)
                    shot = 1'b1;
                if (m_won)
                    hit = 1'b1;
                if (!press)
                    compare_pos("idle torpedo", torpedo_pos, TORPEDO_START);
            end
            @(posedge clk);
            key <= 1'b0;

            if (hit)
            begin
                kind = "hit";
                hits++;
            end
            else if (shot)
            begin
                kind = "miss";
                misses++;
            end
            else
            begin
                kind = "no shot";
                idle++;
            end
            if (error_count != start_errors)
                bad_rounds++;
            $display("round %0d (%s, %0d cycles): %s", round_idx, kind, cycles,
                     (error_count == start_errors) ? "ok" : "mismatches");
        end

        $display("%0d rounds, %0d hits, %0d misses, %0d without shot, %0d bad rounds, %0d errors",
                 ROUNDS, hits, misses, idle, bad_rounds, error_count);
        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
